//--- src/mcast_mux_pkg.sv
/*
 * Shared widths, port count and ID types of the multicast AXI write mux
 */
package mcast_mux_pkg;

  // Manager port count, tied to the two-bit port field of the ID
  localparam int unsigned NumSlvPorts  = 4;
  localparam int unsigned PortIdxWidth = 2;

  // AXI channel widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned LenWidth  = 8;
  localparam int unsigned RespWidth = 2;

  // ID widths on both sides of the mux
  localparam int unsigned SlvIdWidth = 4;
  localparam int unsigned MstIdWidth = SlvIdWidth + PortIdxWidth;

  typedef logic [PortIdxWidth-1:0] port_idx_t;
  typedef logic [SlvIdWidth-1:0]   slv_id_t;

  // Subordinate-side ID split into its two fields
  typedef struct packed {
    port_idx_t port;
    slv_id_t   id;
  } mst_id_fields_t;

  // Subordinate-side ID, seen as a plain word on the bus or as
  // the port index on top of the manager's own ID
  typedef union packed {
    logic [MstIdWidth-1:0] flat;
    mst_id_fields_t        fields;
  } mst_id_t;

endpackage

//--- src/aw_arbiter.sv
/*
 * AW arbitration: multicast by fixed priority, unicast by round-robin,
 * grant lock until acceptance, ID prepend and route queue push control
 */
module aw_arbiter (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  // Manager AW channels
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_aw_valid_i,
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0][mcast_mux_pkg::AddrWidth-1:0] slv_aw_addr_i,
  input  mcast_mux_pkg::slv_id_t [mcast_mux_pkg::NumSlvPorts-1:0] slv_aw_id_i,
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0][mcast_mux_pkg::LenWidth-1:0] slv_aw_len_i,
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_is_mcast_i,
  output logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_aw_ready_o,
  // Subordinate AW channel
  output logic                                  mst_aw_valid_o,
  output logic [mcast_mux_pkg::AddrWidth-1:0]   mst_aw_addr_o,
  output mcast_mux_pkg::mst_id_t                mst_aw_id_o,
  output logic [mcast_mux_pkg::LenWidth-1:0]    mst_aw_len_o,
  input  logic                                  mst_aw_ready_i,
  // Route queue
  output logic                                  route_push_o,
  output mcast_mux_pkg::port_idx_t              route_port_o,
  input  logic                                  route_full_i
);

  logic [mcast_mux_pkg::NumSlvPorts-1:0] mcast_req;
  logic [mcast_mux_pkg::NumSlvPorts-1:0] ucast_req;

  logic                     mcast_valid;
  mcast_mux_pkg::port_idx_t mcast_port;
  logic                     ucast_valid;
  mcast_mux_pkg::port_idx_t ucast_port;
  mcast_mux_pkg::port_idx_t ucast_cand;

  logic                     sel_valid;
  mcast_mux_pkg::port_idx_t sel_port;
  logic                     aw_accept;

  // Grant lock, push flag and round-robin pointer
  logic                     lock_q;
  mcast_mux_pkg::port_idx_t lock_port_q;
  logic                     pushed_q;
  mcast_mux_pkg::port_idx_t rr_ptr_q;

  assign mcast_req = slv_aw_valid_i & slv_is_mcast_i;
  assign ucast_req = slv_aw_valid_i & ~slv_is_mcast_i;

  // --------------------------------------------------------------------------
  // Arbitration
  // --------------------------------------------------------------------------
  always_comb begin
    mcast_valid = 1'b0;
    mcast_port  = '0;
    ucast_valid = 1'b0;
    ucast_port  = '0;
    ucast_cand  = '0;
    // Lowest index multicast requester wins
    for (int unsigned i = 0; i < mcast_mux_pkg::NumSlvPorts; i++) begin
      if (!mcast_valid && mcast_req[i]) begin
        mcast_valid = 1'b1;
        mcast_port  = mcast_mux_pkg::port_idx_t'(i);
      end
    end
    // Unicast search starts at the pointer and wraps around
    for (int unsigned i = 0; i < mcast_mux_pkg::NumSlvPorts; i++) begin
      ucast_cand = rr_ptr_q + mcast_mux_pkg::port_idx_t'(i);
      if (!ucast_valid && ucast_req[ucast_cand]) begin
        ucast_valid = 1'b1;
        ucast_port  = ucast_cand;
      end
    end
  end

  // A locked grant overrides any fresh decision
  assign sel_valid = lock_q | mcast_valid | ucast_valid;
  assign sel_port  = lock_q      ? lock_port_q :
                     mcast_valid ? mcast_port  : ucast_port;

  // --------------------------------------------------------------------------
  // Subordinate AW and route queue push
  // --------------------------------------------------------------------------
  // Once pushed, the AW stays presented even if the queue fills up
  assign mst_aw_valid_o = sel_valid && (pushed_q || !route_full_i);
  assign route_push_o   = sel_valid && !pushed_q && !route_full_i;
  assign route_port_o   = sel_port;
  assign aw_accept      = mst_aw_valid_o && mst_aw_ready_i;

  always_comb begin
    mst_aw_addr_o             = slv_aw_addr_i[sel_port];
    mst_aw_len_o              = slv_aw_len_i[sel_port];
    mst_aw_id_o.fields.port   = sel_port;
    mst_aw_id_o.fields.id     = slv_aw_id_i[sel_port];
    for (int unsigned p = 0; p < mcast_mux_pkg::NumSlvPorts; p++) begin
      slv_aw_ready_o[p] = aw_accept && (sel_port == mcast_mux_pkg::port_idx_t'(p));
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q      <= 1'b0;
      lock_port_q <= '0;
      pushed_q    <= 1'b0;
      rr_ptr_q    <= '0;
    end else begin
      if (aw_accept) begin
        lock_q   <= 1'b0;
        pushed_q <= 1'b0;
      end else if (sel_valid) begin
        // Hold the winner until the subordinate takes it
        lock_q      <= 1'b1;
        lock_port_q <= sel_port;
        if (route_push_o) begin
          pushed_q <= 1'b1;
        end
      end
      // Multicast flag is held stable with the request it belongs to
      if (aw_accept && !slv_is_mcast_i[sel_port]) begin
        rr_ptr_q <= sel_port + mcast_mux_pkg::port_idx_t'(1);
      end
    end
  end

endmodule

//--- src/w_route_fifo.sv
/*
 * Queue of AW port decisions and W beat steering by the head entry
 */
module w_route_fifo #(
  parameter int unsigned MaxWTrans = 4
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  // Route decisions from the AW arbiter
  input  logic                                  route_push_i,
  input  mcast_mux_pkg::port_idx_t              route_port_i,
  output logic                                  route_full_o,
  // Manager W channels
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_w_valid_i,
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0][mcast_mux_pkg::DataWidth-1:0] slv_w_data_i,
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0][mcast_mux_pkg::StrbWidth-1:0] slv_w_strb_i,
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_w_last_i,
  output logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_w_ready_o,
  // Subordinate W channel
  output logic                                  mst_w_valid_o,
  output logic [mcast_mux_pkg::DataWidth-1:0]   mst_w_data_o,
  output logic [mcast_mux_pkg::StrbWidth-1:0]   mst_w_strb_o,
  output logic                                  mst_w_last_o,
  input  logic                                  mst_w_ready_i
);

  localparam int unsigned PtrWidth = (MaxWTrans > 1) ? $clog2(MaxWTrans) : 1;
  localparam int unsigned CntWidth = $clog2(MaxWTrans + 1);

  mcast_mux_pkg::port_idx_t [MaxWTrans-1:0] queue_q;
  logic [PtrWidth-1:0]      wr_ptr_q;
  logic [PtrWidth-1:0]      rd_ptr_q;
  logic [CntWidth-1:0]      count_q;

  logic                     empty;
  logic                     push;
  logic                     pop;
  mcast_mux_pkg::port_idx_t head_port;

  // Circular increment, also for depths that are not a power of two
  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(MaxWTrans - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // --------------------------------------------------------------------------
  // Decision queue
  // --------------------------------------------------------------------------
  assign empty        = (count_q == '0);
  assign route_full_o = (count_q == CntWidth'(MaxWTrans));
  assign push         = route_push_i && !route_full_o;
  assign head_port    = queue_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= route_port_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // W steering
  // --------------------------------------------------------------------------
  always_comb begin
    mst_w_valid_o = !empty && slv_w_valid_i[head_port];
    mst_w_data_o  = slv_w_data_i[head_port];
    mst_w_strb_o  = slv_w_strb_i[head_port];
    mst_w_last_o  = slv_w_last_i[head_port];
    // Only the head port sees ready
    for (int unsigned p = 0; p < mcast_mux_pkg::NumSlvPorts; p++) begin
      slv_w_ready_o[p] = !empty && mst_w_ready_i &&
                         (head_port == mcast_mux_pkg::port_idx_t'(p));
    end
  end

  // Burst done, move on to the next decision
  assign pop = mst_w_valid_o && mst_w_ready_i && mst_w_last_o;

endmodule

//--- src/b_router.sv
/*
 * B response steering by the port field of the ID, with ID stripping
 */
module b_router (
  // Subordinate B channel
  input  logic                                  mst_b_valid_i,
  input  mcast_mux_pkg::mst_id_t                mst_b_id_i,
  input  logic [mcast_mux_pkg::RespWidth-1:0]   mst_b_resp_i,
  output logic                                  mst_b_ready_o,
  // Manager B channels
  output logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_b_valid_o,
  output mcast_mux_pkg::slv_id_t [mcast_mux_pkg::NumSlvPorts-1:0] slv_b_id_o,
  output logic [mcast_mux_pkg::NumSlvPorts-1:0][mcast_mux_pkg::RespWidth-1:0] slv_b_resp_o,
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_b_ready_i
);

  mcast_mux_pkg::port_idx_t b_port;

  // Upper ID bits name the manager that issued the write
  assign b_port = mst_b_id_i.fields.port;

  always_comb begin
    for (int unsigned p = 0; p < mcast_mux_pkg::NumSlvPorts; p++) begin
      slv_b_valid_o[p] = mst_b_valid_i && (b_port == mcast_mux_pkg::port_idx_t'(p));
      // Payload goes everywhere, valid picks the receiver
      slv_b_id_o[p]    = mst_b_id_i.fields.id;
      slv_b_resp_o[p]  = mst_b_resp_i;
    end
  end

  assign mst_b_ready_o = slv_b_ready_i[b_port];

endmodule

//--- src/axi_mcast_mux.sv
/*
 * Write half of a four-port AXI mux with multicast priority
 */
module axi_mcast_mux #(
  parameter int unsigned MaxWTrans = 4
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  // Manager AW channels
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_aw_valid_i,
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0][mcast_mux_pkg::AddrWidth-1:0] slv_aw_addr_i,
  input  mcast_mux_pkg::slv_id_t [mcast_mux_pkg::NumSlvPorts-1:0] slv_aw_id_i,
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0][mcast_mux_pkg::LenWidth-1:0] slv_aw_len_i,
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_is_mcast_i,
  output logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_aw_ready_o,
  // Manager W channels
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_w_valid_i,
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0][mcast_mux_pkg::DataWidth-1:0] slv_w_data_i,
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0][mcast_mux_pkg::StrbWidth-1:0] slv_w_strb_i,
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_w_last_i,
  output logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_w_ready_o,
  // Manager B channels
  output logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_b_valid_o,
  output mcast_mux_pkg::slv_id_t [mcast_mux_pkg::NumSlvPorts-1:0] slv_b_id_o,
  output logic [mcast_mux_pkg::NumSlvPorts-1:0][mcast_mux_pkg::RespWidth-1:0] slv_b_resp_o,
  input  logic [mcast_mux_pkg::NumSlvPorts-1:0] slv_b_ready_i,
  // Subordinate AW channel
  output logic                                  mst_aw_valid_o,
  output logic [mcast_mux_pkg::AddrWidth-1:0]   mst_aw_addr_o,
  output mcast_mux_pkg::mst_id_t                mst_aw_id_o,
  output logic [mcast_mux_pkg::LenWidth-1:0]    mst_aw_len_o,
  input  logic                                  mst_aw_ready_i,
  // Subordinate W channel
  output logic                                  mst_w_valid_o,
  output logic [mcast_mux_pkg::DataWidth-1:0]   mst_w_data_o,
  output logic [mcast_mux_pkg::StrbWidth-1:0]   mst_w_strb_o,
  output logic                                  mst_w_last_o,
  input  logic                                  mst_w_ready_i,
  // Subordinate B channel
  input  logic                                  mst_b_valid_i,
  input  mcast_mux_pkg::mst_id_t                mst_b_id_i,
  input  logic [mcast_mux_pkg::RespWidth-1:0]   mst_b_resp_i,
  output logic                                  mst_b_ready_o
);

  // Route decisions from AW to W
  logic                     route_push;
  mcast_mux_pkg::port_idx_t route_port;
  logic                     route_full;

  aw_arbiter i_aw_arbiter (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .slv_aw_valid_i ( slv_aw_valid_i ),
    .slv_aw_addr_i  ( slv_aw_addr_i  ),
    .slv_aw_id_i    ( slv_aw_id_i    ),
    .slv_aw_len_i   ( slv_aw_len_i   ),
    .slv_is_mcast_i ( slv_is_mcast_i ),
    .slv_aw_ready_o ( slv_aw_ready_o ),
    .mst_aw_valid_o ( mst_aw_valid_o ),
    .mst_aw_addr_o  ( mst_aw_addr_o  ),
    .mst_aw_id_o    ( mst_aw_id_o    ),
    .mst_aw_len_o   ( mst_aw_len_o   ),
    .mst_aw_ready_i ( mst_aw_ready_i ),
    .route_push_o   ( route_push     ),
    .route_port_o   ( route_port     ),
    .route_full_i   ( route_full     )
  );

  // The queue depth bounds the writes in flight
  w_route_fifo #(
    .MaxWTrans ( MaxWTrans )
  ) i_w_route_fifo (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .route_push_i  ( route_push    ),
    .route_port_i  ( route_port    ),
    .route_full_o  ( route_full    ),
    .slv_w_valid_i ( slv_w_valid_i ),
    .slv_w_data_i  ( slv_w_data_i  ),
    .slv_w_strb_i  ( slv_w_strb_i  ),
    .slv_w_last_i  ( slv_w_last_i  ),
    .slv_w_ready_o ( slv_w_ready_o ),
    .mst_w_valid_o ( mst_w_valid_o ),
    .mst_w_data_o  ( mst_w_data_o  ),
    .mst_w_strb_o  ( mst_w_strb_o  ),
    .mst_w_last_o  ( mst_w_last_o  ),
    .mst_w_ready_i ( mst_w_ready_i )
  );

  b_router i_b_router (
    .mst_b_valid_i ( mst_b_valid_i ),
    .mst_b_id_i    ( mst_b_id_i    ),
    .mst_b_resp_i  ( mst_b_resp_i  ),
    .mst_b_ready_o ( mst_b_ready_o ),
    .slv_b_valid_o ( slv_b_valid_o ),
    .slv_b_id_o    ( slv_b_id_o    ),
    .slv_b_resp_o  ( slv_b_resp_o  ),
    .slv_b_ready_i ( slv_b_ready_i )
  );

endmodule

//--- tb/axi_mcast_mux_props.sv
/*
 * Handshake properties of the subordinate-side channels and B routing
 */
module axi_mcast_mux_props (
  input logic                                  clk_i,
  input logic                                  reset_i,
  input logic                                  aw_valid_i,
  input logic                                  aw_ready_i,
  input logic [mcast_mux_pkg::AddrWidth-1:0]   aw_addr_i,
  input logic [mcast_mux_pkg::MstIdWidth-1:0]  aw_id_i,
  input logic [mcast_mux_pkg::LenWidth-1:0]    aw_len_i,
  input logic                                  w_valid_i,
  input logic                                  w_ready_i,
  input logic [mcast_mux_pkg::DataWidth-1:0]   w_data_i,
  input logic [mcast_mux_pkg::StrbWidth-1:0]   w_strb_i,
  input logic                                  w_last_i,
  input logic [mcast_mux_pkg::NumSlvPorts-1:0] b_valid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failed properties so far
  int unsigned fail_count = 0;

  // AW request holds until the subordinate takes it
  aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (aw_valid_i && !aw_ready_i) |=> (aw_valid_i && $stable({aw_addr_i, aw_id_i, aw_len_i})))
    else begin
      $error("AW valid or payload changed while waiting for ready");
      fail_count++;
    end

  // Same rule on the W beat
  w_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (w_valid_i && !w_ready_i) |=> (w_valid_i && $stable({w_data_i, w_strb_i, w_last_i})))
    else begin
      $error("W valid or payload changed while waiting for ready");
      fail_count++;
    end

  // A response goes to at most one manager
  b_single: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(b_valid_i))
    else begin
      $error("B valid raised on more than one manager port");
      fail_count++;
    end

endmodule

//--- tb/tb_axi_mcast_mux.sv
/*
 * Directed testbench of the multicast AXI write mux: clock and reset,
 * manager and subordinate models, AW/W logs and the test sequence
 */
module tb_axi_mcast_mux;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumPorts     = mcast_mux_pkg::NumSlvPorts;
  localparam int unsigned PortIdxWidth = mcast_mux_pkg::PortIdxWidth;
  localparam int unsigned AddrWidth    = mcast_mux_pkg::AddrWidth;
  localparam int unsigned DataWidth    = mcast_mux_pkg::DataWidth;
  localparam int unsigned StrbWidth    = mcast_mux_pkg::StrbWidth;
  localparam int unsigned SlvIdWidth   = mcast_mux_pkg::SlvIdWidth;
  localparam int unsigned MstIdWidth   = mcast_mux_pkg::MstIdWidth;
  localparam int unsigned LenWidth     = mcast_mux_pkg::LenWidth;
  localparam int unsigned RespWidth    = mcast_mux_pkg::RespWidth;
  localparam int unsigned MaxWTrans    = 4;
  localparam int unsigned ClkPeriod    = 40;
  // Outputs are sampled 1 ns before the rising edge
  localparam int unsigned SampleDelay  = ClkPeriod / 2 - 1;
  localparam int unsigned Timeout      = 200;
  localparam logic [LenWidth-1:0] BurstLen = 8'd1;

  logic                                  clk_i;
  logic                                  reset_i;
  logic [NumPorts-1:0]                   slv_aw_valid_i;
  logic [NumPorts-1:0][AddrWidth-1:0]    slv_aw_addr_i;
  logic [NumPorts-1:0][SlvIdWidth-1:0]   slv_aw_id_i;
  logic [NumPorts-1:0][LenWidth-1:0]     slv_aw_len_i;
  logic [NumPorts-1:0]                   slv_is_mcast_i;
  logic [NumPorts-1:0]                   slv_aw_ready_o;
  logic [NumPorts-1:0]                   slv_w_valid_i;
  logic [NumPorts-1:0][DataWidth-1:0]    slv_w_data_i;
  logic [NumPorts-1:0][StrbWidth-1:0]    slv_w_strb_i;
  logic [NumPorts-1:0]                   slv_w_last_i;
  logic [NumPorts-1:0]                   slv_w_ready_o;
  logic [NumPorts-1:0]                   slv_b_valid_o;
  logic [NumPorts-1:0][SlvIdWidth-1:0]   slv_b_id_o;
  logic [NumPorts-1:0][RespWidth-1:0]    slv_b_resp_o;
  logic [NumPorts-1:0]                   slv_b_ready_i;
  logic                                  mst_aw_valid_o;
  logic [AddrWidth-1:0]                  mst_aw_addr_o;
  logic [MstIdWidth-1:0]                 mst_aw_id_o;
  logic [LenWidth-1:0]                   mst_aw_len_o;
  logic                                  mst_aw_ready_i;
  logic                                  mst_w_valid_o;
  logic [DataWidth-1:0]                  mst_w_data_o;
  logic [StrbWidth-1:0]                  mst_w_strb_o;
  logic                                  mst_w_last_o;
  logic                                  mst_w_ready_i;
  logic                                  mst_b_valid_i;
  logic [MstIdWidth-1:0]                 mst_b_id_i;
  logic [RespWidth-1:0]                  mst_b_resp_i;
  logic                                  mst_b_ready_o;

  // Transfers seen on the subordinate side, in order
  logic [MstIdWidth-1:0] aw_id_log[$];
  logic [AddrWidth-1:0]  aw_addr_log[$];
  logic [LenWidth-1:0]   aw_len_log[$];
  logic [DataWidth-1:0]  w_data_log[$];
  logic [StrbWidth-1:0]  w_strb_log[$];
  logic                  w_last_log[$];
  int                    seed;

  axi_mcast_mux #(
    .MaxWTrans ( MaxWTrans )
  ) axi_mcast_mux_inst (.*);

  bind axi_mcast_mux axi_mcast_mux_props props_inst (
    .clk_i      ( clk_i          ),
    .reset_i    ( reset_i        ),
    .aw_valid_i ( mst_aw_valid_o ),
    .aw_ready_i ( mst_aw_ready_i ),
    .aw_addr_i  ( mst_aw_addr_o  ),
    .aw_id_i    ( mst_aw_id_o    ),
    .aw_len_i   ( mst_aw_len_o   ),
    .w_valid_i  ( mst_w_valid_o  ),
    .w_ready_i  ( mst_w_ready_i  ),
    .w_data_i   ( mst_w_data_o   ),
    .w_strb_i   ( mst_w_strb_o   ),
    .w_last_i   ( mst_w_last_o   ),
    .b_valid_i  ( slv_b_valid_o  )
  );

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  always begin
    @(negedge clk_i);
    #(SampleDelay);
    if (!reset_i && mst_aw_valid_o && mst_aw_ready_i) begin
      aw_id_log.push_back(mst_aw_id_o);
      aw_addr_log.push_back(mst_aw_addr_o);
      aw_len_log.push_back(mst_aw_len_o);
    end
    if (!reset_i && mst_w_valid_o && mst_w_ready_i) begin
      w_data_log.push_back(mst_w_data_o);
      w_strb_log.push_back(mst_w_strb_o);
      w_last_log.push_back(mst_w_last_o);
    end
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  task automatic flag_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic abort_on_property();
    $display("A handshake property of the DUT failed at %0t ns", $time);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // A failed handshake property ends the run
  always @(axi_mcast_mux_inst.props_inst.fail_count) begin
    assert (axi_mcast_mux_inst.props_inst.fail_count == 0)
      else abort_on_property();
  end

  function automatic logic [SlvIdWidth-1:0] aw_id_for(input int p, input int k);
    return SlvIdWidth'(4 * k + p + 5);
  endfunction

  function automatic logic [AddrWidth-1:0] aw_addr_for(input int p, input int k);
    return 32'h1000_0000 + AddrWidth'(p * 'h100) + AddrWidth'(k * 'h10);
  endfunction

  // Beat word carries port, burst number and beat number
  function automatic logic [DataWidth-1:0] beat_word(input int p, input int k, input int b);
    return {8'(8'hD0 + p), 8'(k), 8'(b), 8'h5A};
  endfunction

  function automatic logic [StrbWidth-1:0] beat_strb(input int p, input int b);
    return StrbWidth'(1 << ((p + b) % StrbWidth));
  endfunction

  // Port index sits in the upper ID bits
  function automatic int port_of(input logic [MstIdWidth-1:0] id);
    return int'(id[MstIdWidth-1 -: PortIdxWidth]);
  endfunction

  task automatic clear_logs();
    aw_id_log.delete();
    aw_addr_log.delete();
    aw_len_log.delete();
    w_data_log.delete();
    w_strb_log.delete();
    w_last_log.delete();
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    reset_i = 1'b1;
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    #(SampleDelay);
    assert (!mst_aw_valid_o && !mst_w_valid_o && slv_b_valid_o == '0)
      else flag_mismatch("outputs not idle after reset");
  endtask

  // ------------------------------------------------------------------------
  // Manager models
  // ------------------------------------------------------------------------
  task automatic issue_aw(input int p, input int k, input logic mcast);
    int unsigned t;
    t = 0;
    @(negedge clk_i);
    slv_aw_valid_i[p] = 1'b1;
    slv_aw_id_i[p]    = aw_id_for(p, k);
    slv_aw_addr_i[p]  = aw_addr_for(p, k);
    slv_aw_len_i[p]   = BurstLen;
    slv_is_mcast_i[p] = mcast;
    #(SampleDelay);
    while (!slv_aw_ready_o[p]) begin
      t++;
      if (t > Timeout) begin
        abort_on_timeout($sformatf("AW ready on port %0d", p));
      end
      @(negedge clk_i);
      #(SampleDelay);
    end
    @(negedge clk_i);
    slv_aw_valid_i[p] = 1'b0;
    slv_is_mcast_i[p] = 1'b0;
  endtask

  task automatic stream_w(input int p, input int k);
    int unsigned t;
    for (int b = 0; b <= int'(BurstLen); b++) begin
      t = 0;
      @(negedge clk_i);
      slv_w_valid_i[p] = 1'b1;
      slv_w_data_i[p]  = beat_word(p, k, b);
      slv_w_strb_i[p]  = beat_strb(p, b);
      slv_w_last_i[p]  = (b == int'(BurstLen));
      #(SampleDelay);
      while (!slv_w_ready_o[p]) begin
        t++;
        if (t > Timeout) begin
          abort_on_timeout($sformatf("W ready on port %0d", p));
        end
        @(negedge clk_i);
        #(SampleDelay);
      end
    end
    @(negedge clk_i);
    slv_w_valid_i[p] = 1'b0;
    slv_w_last_i[p]  = 1'b0;
  endtask

  task automatic port_traffic(input int p, input int bursts, input logic mcast);
    fork
      for (int k = 0; k < bursts; k++) begin
        issue_aw(p, k, mcast);
      end
      for (int k = 0; k < bursts; k++) begin
        stream_w(p, k);
      end
    join
  endtask

  // Subordinate B response, optionally with random manager ready
  task automatic respond_b(input logic [MstIdWidth-1:0] id, input logic [RespWidth-1:0] resp,
                           input logic stall);
    int unsigned t;
    int          p;
    logic        done;
    t    = 0;
    done = 1'b0;
    p    = port_of(id);
    @(negedge clk_i);
    mst_b_valid_i = 1'b1;
    mst_b_id_i    = id;
    mst_b_resp_i  = resp;
    while (!done) begin
      slv_b_ready_i = stall ? NumPorts'($random(seed)) : '1;
      #(SampleDelay);
      assert (slv_b_valid_o == (NumPorts'(1) << p))
        else flag_mismatch($sformatf("B valid %b for ID %h", slv_b_valid_o, id));
      assert (slv_b_id_o[p] == id[SlvIdWidth-1:0] && slv_b_resp_o[p] == resp)
        else flag_mismatch($sformatf("B payload wrong on port %0d", p));
      assert (mst_b_ready_o == slv_b_ready_i[p])
        else flag_mismatch("B ready not taken from the addressed port");
      done = mst_b_ready_o;
      if (!done) begin
        t++;
        if (t > Timeout) begin
          abort_on_timeout("B handshake");
        end
        @(negedge clk_i);
      end
    end
    @(negedge clk_i);
    mst_b_valid_i = 1'b0;
    slv_b_ready_i = '1;
  endtask

  // Each AW is its port's next burst, W beats follow AW acceptance order
  task automatic check_w_order();
    int burst_cnt[NumPorts];
    int idx;
    int p;
    idx = 0;
    for (int i = 0; i < NumPorts; i++) begin
      burst_cnt[i] = 0;
    end
    for (int a = 0; a < aw_id_log.size(); a++) begin
      p = port_of(aw_id_log[a]);
      assert (aw_id_log[a][SlvIdWidth-1:0] == aw_id_for(p, burst_cnt[p]) &&
              aw_addr_log[a] == aw_addr_for(p, burst_cnt[p]) &&
              aw_len_log[a] == BurstLen)
        else flag_mismatch($sformatf("AW %0d has ID %h", a, aw_id_log[a]));
      for (int b = 0; b <= int'(BurstLen); b++) begin
        assert (idx < w_data_log.size()) else flag_mismatch("W beat missing");
        assert (w_data_log[idx] == beat_word(p, burst_cnt[p], b) &&
                w_strb_log[idx] == beat_strb(p, b))
          else flag_mismatch($sformatf("W beat %0d is %h", idx, w_data_log[idx]));
        assert (w_last_log[idx] == (b == int'(BurstLen)))
          else flag_mismatch($sformatf("W last wrong on beat %0d", idx));
        idx++;
      end
      burst_cnt[p]++;
    end
    assert (idx == w_data_log.size()) else flag_mismatch("extra W beats");
  endtask

  // ------------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------------
  task automatic unicast_per_port();
    logic [MstIdWidth-1:0] exp_id;
    for (int p = 0; p < NumPorts; p++) begin
      clear_logs();
      port_traffic(p, 1, 1'b0);
      exp_id = {PortIdxWidth'(p), aw_id_for(p, 0)};
      assert (aw_id_log.size() == 1) else flag_mismatch("AW count not one");
      assert (aw_id_log[0] == exp_id && aw_addr_log[0] == aw_addr_for(p, 0) &&
              aw_len_log[0] == BurstLen)
        else flag_mismatch($sformatf("AW from port %0d has ID %h", p, aw_id_log[0]));
      check_w_order();
      respond_b(exp_id, RespWidth'(p), 1'b0);
    end
  endtask

  task automatic round_robin_order();
    clear_logs();
    fork
      port_traffic(0, 1, 1'b0);
      port_traffic(1, 1, 1'b0);
      port_traffic(2, 1, 1'b0);
      port_traffic(3, 1, 1'b0);
    join
    assert (aw_id_log.size() == NumPorts) else flag_mismatch("AW count wrong");
    for (int a = 0; a < NumPorts; a++) begin
      assert (port_of(aw_id_log[a]) == a)
        else flag_mismatch($sformatf("grant %0d went to port %0d", a, port_of(aw_id_log[a])));
    end
    check_w_order();
  endtask

  task automatic mcast_priority();
    clear_logs();
    fork
      port_traffic(0, 1, 1'b0);
      port_traffic(1, 1, 1'b1);
      port_traffic(2, 1, 1'b0);
      port_traffic(3, 1, 1'b1);
    join
    assert (aw_id_log.size() == NumPorts) else flag_mismatch("AW count wrong");
    assert (port_of(aw_id_log[0]) == 1 && port_of(aw_id_log[1]) == 3)
      else flag_mismatch("multicast ports not served first");
    check_w_order();
  endtask

  task automatic aw_backpressure();
    int unsigned           t;
    int unsigned           stall_cycles;
    logic [MstIdWidth-1:0] held_id;
    logic [AddrWidth-1:0]  held_addr;
    clear_logs();
    t            = 0;
    stall_cycles = 4 + ($unsigned($random(seed)) % 8);
    @(negedge clk_i);
    mst_aw_ready_i = 1'b0;
    fork
      port_traffic(0, 1, 1'b0);
      begin
        // Multicast request shows up while port 0 is held
        repeat (2) @(negedge clk_i);
        port_traffic(2, 1, 1'b1);
      end
      begin
        @(negedge clk_i);
        #(SampleDelay);
        while (!mst_aw_valid_o) begin
          t++;
          if (t > Timeout) begin
            abort_on_timeout("AW valid under back-pressure");
          end
          @(negedge clk_i);
          #(SampleDelay);
        end
        held_id   = mst_aw_id_o;
        held_addr = mst_aw_addr_o;
        assert (held_id == {PortIdxWidth'(0), aw_id_for(0, 0)})
          else flag_mismatch($sformatf("presented AW ID %h", held_id));
        repeat (stall_cycles) begin
          @(negedge clk_i);
          #(SampleDelay);
          assert (mst_aw_valid_o && mst_aw_id_o == held_id && mst_aw_addr_o == held_addr)
            else flag_mismatch("presented AW changed while stalled");
        end
        @(negedge clk_i);
        mst_aw_ready_i = 1'b1;
      end
    join
    assert (aw_id_log.size() == 2 && aw_id_log[0] == held_id && port_of(aw_id_log[1]) == 2)
      else flag_mismatch("AW order after back-pressure");
    check_w_order();
  endtask

  task automatic outstanding_limit();
    int unsigned t;
    int          exp_order[6] = '{1, 2, 3, 0, 1, 0};
    clear_logs();
    t = 0;
    @(negedge clk_i);
    mst_w_ready_i = 1'b0;
    fork
      port_traffic(0, 2, 1'b0);
      port_traffic(1, 2, 1'b0);
      port_traffic(2, 1, 1'b0);
      port_traffic(3, 1, 1'b0);
      begin
        while (aw_id_log.size() < MaxWTrans) begin
          t++;
          if (t > Timeout) begin
            abort_on_timeout("AW acceptances up to the limit");
          end
          @(negedge clk_i);
        end
        repeat (8) begin
          @(negedge clk_i);
          assert (aw_id_log.size() == MaxWTrans)
            else flag_mismatch($sformatf("%0d AWs outstanding", aw_id_log.size()));
          #(SampleDelay);
          assert (!mst_aw_valid_o) else flag_mismatch("AW presented with full queue");
        end
        @(negedge clk_i);
        mst_w_ready_i = 1'b1;
      end
    join
    assert (aw_id_log.size() == 6) else flag_mismatch("AW count wrong");
    // Pointer sits at port 1, after the last unicast grant to port 0
    for (int a = 0; a < 6; a++) begin
      assert (port_of(aw_id_log[a]) == exp_order[a])
        else flag_mismatch($sformatf("grant %0d went to port %0d", a, port_of(aw_id_log[a])));
    end
    check_w_order();
  endtask

  task automatic b_routing_stalls();
    logic [MstIdWidth-1:0] id;
    logic [RespWidth-1:0]  resp;
    for (int k = 0; k < 16; k++) begin
      id   = MstIdWidth'($random(seed));
      resp = RespWidth'($random(seed));
      respond_b(id, resp, 1'b1);
    end
  endtask

  initial begin
    seed           = 98846;
    reset_i        = 1'b1;
    slv_aw_valid_i = '0;
    slv_aw_addr_i  = '0;
    slv_aw_id_i    = '0;
    slv_aw_len_i   = '0;
    slv_is_mcast_i = '0;
    slv_w_valid_i  = '0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_w_last_i   = '0;
    slv_b_ready_i  = '1;
    mst_aw_ready_i = 1'b1;
    mst_w_ready_i  = 1'b1;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    apply_reset();
    unicast_per_port();
    apply_reset();
    round_robin_order();
    mcast_priority();
    aw_backpressure();
    outstanding_limit();
    b_routing_stalls();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- all.f
src/mcast_mux_pkg.sv
src/aw_arbiter.sv
src/w_route_fifo.sv
src/b_router.sv
src/axi_mcast_mux.sv
tb/axi_mcast_mux_props.sv
tb/tb_axi_mcast_mux.sv

//--- Bender.yml
package:
  name: axi_mcast_mux

sources:
  - src/mcast_mux_pkg.sv
  - src/aw_arbiter.sv
  - src/w_route_fifo.sv
  - src/b_router.sv
  - src/axi_mcast_mux.sv
  - target: test
    files:
      - tb/axi_mcast_mux_props.sv
      - tb/tb_axi_mcast_mux.sv
